//--- all.f
+incdir+design
design/spi_loader_pkg.sv
design/spi_word_rx.sv
design/spi_word_tx.sv
design/spi_write_sequencer.sv
design/spi_mem_loader.sv
sim/spi_loader_checker.sv
sim/spi_loader_tb.sv

//--- Bender.yml
package:
  name: spi_mem_loader

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/spi_loader_pkg.sv
      - design/spi_word_rx.sv
      - design/spi_word_tx.sv
      - design/spi_write_sequencer.sv
      - design/spi_mem_loader.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/spi_loader_checker.sv
      - sim/spi_loader_tb.sv

//--- sim/spi_loader_tb.sv
/*
 * SPI memory loader testbench
 * Clock, reset, random SPI master, memory model with random ready
 * and the run timeout
 */

`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_macros.svh"

module spi_loader_tb;
  import spi_loader_pkg::*;

  localparam int HALF_SCLK   = 8;
  localparam int RAND_FRAMES = 4;
  localparam int RAND_PAIRS  = 2;
  localparam int LONG_STALL  = 700;
  // Go frame, random frames, partial, completion, stall, two closing frames
  localparam int WORDS_SENT = 10 + RAND_FRAMES * RAND_PAIRS * 2 + 2 + 3 + 5 + 2 + 2;
  localparam int TIMEOUT_CYCLES = WORDS_SENT * 32 * 16 + 2000;

  logic     clk, rst, cs, sclk, mosi, miso;
  logic     mem_req_val, mem_req_rdy, go, end_of_test;
  logic     long_stall, xfer_seen;
  mem_req_t mem_req;
  int       errors, transfers, f, p;
  int       cycles = 0;
  int       wait_left = -1;

  spi_mem_loader dut_i (
    .clk         (clk),
    .rst         (rst),
    .cs          (cs),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso),
    .mem_req     (mem_req),
    .mem_req_val (mem_req_val),
    .mem_req_rdy (mem_req_rdy),
    .go          (go)
  );

  spi_loader_checker chk_i (
    .clk         (clk),
    .rst         (rst),
    .cs          (cs),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso),
    .mem_req     (mem_req),
    .mem_req_val (mem_req_val),
    .mem_req_rdy (mem_req_rdy),
    .go          (go),
    .end_of_test (end_of_test),
    .errors      (errors)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------
  // Memory model with a random wait per request or one long stall
  // ----------------------------------------------------------

  always @(posedge clk) begin
    xfer_seen = mem_req_val && mem_req_rdy;
    if (xfer_seen) transfers++;
    #1;
    mem_req_rdy = 1'b0;
    if (rst || xfer_seen || !mem_req_val) begin
      wait_left = -1;
    end else begin
      if (wait_left < 0) begin
        wait_left  = long_stall ? LONG_STALL : $urandom_range(20, 0);
        long_stall = 1'b0;
      end
      if (wait_left == 0) mem_req_rdy = 1'b1;
      else wait_left--;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d", errors);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // SPI master in mode 0
  // ----------------------------------------------------------

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic send_bits(input logic [31:0] w, input int nbits);
    int i;
    for (i = 0; i < nbits; i++) begin
      mosi = w[31 - i];
      step(HALF_SCLK);
      sclk = 1'b1;
      step(HALF_SCLK);
      sclk = 1'b0;
    end
  endtask

  task automatic send_pair(input logic [31:0] a, input logic [31:0] d);
    send_bits(a, 32);
    send_bits(d, 32);
  endtask

  // Memory quiet for a while, then cs low
  task automatic begin_frame();
    int quiet;
    quiet = 0;
    while (quiet < 30) begin
      step(1);
      quiet = mem_req_val ? 0 : quiet + 1;
    end
    cs = 1'b0;
    step(HALF_SCLK);
  endtask

  task automatic end_frame();
    step(HALF_SCLK);
    cs = 1'b1;
    step(HALF_SCLK);
  endtask

  function automatic logic [31:0] rand_addr();
    logic [31:0] a;
    a = $urandom;
    if (a == `LOADER_GO_ADDR) a = 32'h0000_0004;
    return a;
  endfunction

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    void'($urandom(64243));
    {clk, cs, rst} = 3'b011;
    {sclk, mosi, mem_req_rdy, long_stall, end_of_test} = '0;
    transfers = 0;
    step(4);
    rst = 1'b0;

    // Go cleared, plain writes, then go set again
    begin_frame();
    send_pair(`LOADER_GO_ADDR, $urandom & 32'hffff_fffe);
    for (p = 0; p < 3; p++) send_pair(rand_addr(), $urandom);
    send_pair(`LOADER_GO_ADDR, $urandom | 32'h0000_0001);
    end_frame();

    // Random pairs with some to the control register
    for (f = 0; f < RAND_FRAMES; f++) begin
      begin_frame();
      for (p = 0; p < RAND_PAIRS; p++) begin
        send_pair(($urandom_range(3, 0) == 0) ? `LOADER_GO_ADDR : rand_addr(), $urandom);
      end
      end_frame();
    end

    // Address, then a cut-off word, data in the next frame
    begin_frame();
    send_bits(rand_addr(), 32);
    send_bits($urandom, $urandom_range(31, 1));
    end_frame();
    begin_frame();
    send_bits($urandom, 32);
    send_pair(rand_addr(), $urandom);
    end_frame();

    // Third word lands in a long stall
    long_stall = 1'b1;
    begin_frame();
    send_pair(rand_addr(), $urandom);
    send_bits($urandom, 32);
    send_pair(rand_addr(), $urandom);
    end_frame();

    // Overrun seen, then cleared
    for (f = 0; f < 2; f++) begin
      begin_frame();
      send_pair(rand_addr(), $urandom);
      end_frame();
    end

    begin_frame();
    cs = 1'b1;
    end_of_test = 1'b1;
    step(2);
    $display("Errors: %0d, memory writes: %0d", errors, transfers);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/spi_loader_checker.sv
/*
 * Checker for the SPI memory loader: reference model of word pairing,
 * go and status, compared against the memory port, go and miso
 */

`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_macros.svh"

module spi_loader_checker
  import spi_loader_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     cs,
  input  logic     sclk,
  input  logic     mosi,
  input  logic     miso,
  input  mem_req_t mem_req,
  input  logic     mem_req_val,
  input  logic     mem_req_rdy,
  input  logic     go,
  input  logic     end_of_test,
  output int       errors
);

  // Pin sclk rise to rx_push seen by the sequencer
  localparam int RX_DELAY = 3;

  logic [`SPI_WORD_BITS-1:0]     exp_addr_q[$];
  logic [`SPI_WORD_BITS-1:0]     exp_data_q[$];
  logic [`SPI_WORD_BITS-1:0]     word_sr;
  logic [`SPI_WORD_BITS-1:0]     miso_sr;
  logic [`SPI_WORD_BITS-1:0]     new_word;
  logic [`SPI_WORD_BITS-1:0]     addr_m;
  logic [`STATUS_COUNT_BITS-1:0] count_m;
  spi_status_t                   status_exp;
  mem_req_t                      held;
  logic sclk_d, cs_d, have_addr, pending, first_word, overrun_m, go_m;
  logic held_valid, status_read;
  int   bit_n, apply_in, go_check_in;

  initial errors = 0;

  // ----------------------------------------------------------
  // Model of the sequencer, one word at its push time
  // ----------------------------------------------------------

  task automatic apply_word(input logic [`SPI_WORD_BITS-1:0] w);
    logic dropped;
    dropped = pending;
    if (!dropped && !have_addr) begin
      addr_m    = w;
      have_addr = 1'b1;
    end else if (!dropped) begin
      have_addr = 1'b0;
      if (addr_m == `LOADER_GO_ADDR) begin
        go_m        = w[0];
        go_check_in = 3;
      end else begin
        exp_addr_q.push_back(addr_m);
        exp_data_q.push_back(w);
        pending = 1'b1;
      end
    end
    // First word of a frame restarts the overrun history
    if (first_word) overrun_m = dropped;
    else if (dropped) overrun_m = 1'b1;
    first_word = 1'b0;
  endtask

  task automatic check_transfer();
    logic [`SPI_WORD_BITS-1:0] a;
    logic [`SPI_WORD_BITS-1:0] d;
    if (exp_addr_q.size() == 0) begin
      $display("Unexpected memory write to address %h at %0t", mem_req.addr, $time);
      errors++;
    end else begin
      a = exp_addr_q.pop_front();
      d = exp_data_q.pop_front();
      if (mem_req.op !== `MEM_OP_WRITE || mem_req.len !== 4'hf) begin
        $display("FAILED %0t: op %b len %h, expected write with all bytes",
                 $time, mem_req.op, mem_req.len);
        errors++;
      end
      if (mem_req.addr !== a || mem_req.data !== d) begin
        $display("FAILED %0t: write %h <= %h, expected %h <= %h",
                 $time, mem_req.addr, mem_req.data, a, d);
        errors++;
      end
    end
    count_m++;
    pending = 1'b0;
  endtask

  task automatic check_go();
    if (go !== go_m) begin
      $display("FAILED %0t: go is %b, expected %b", $time, go, go_m);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // Sampling at each clock edge
  // ----------------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      exp_addr_q.delete();
      exp_data_q.delete();
      {have_addr, pending, first_word, overrun_m} = '0;
      {held_valid, status_read, sclk_d} = '0;
      go_m        = 1'b1;
      cs_d        = 1'b1;
      count_m     = '0;
      bit_n       = 0;
      apply_in    = 0;
      go_check_in = 0;
    end else begin
      // Word reaches the sequencer before this edge's transfer
      if (apply_in > 0) begin
        apply_in--;
        if (apply_in == 0) apply_word(new_word);
      end
      if (mem_req_val) begin
        if (held_valid && mem_req !== held) begin
          $display("FAILED %0t: mem_req changed while waiting, %h was %h",
                   $time, mem_req, held);
          errors++;
        end
        if (mem_req_rdy) begin
          check_transfer();
          held_valid = 1'b0;
        end else begin
          held_valid = 1'b1;
          held       = mem_req;
        end
      end else if (held_valid) begin
        $display("Request valid dropped without a transfer at %0t", $time);
        errors++;
        held_valid = 1'b0;
      end
      if (go_check_in > 0) begin
        go_check_in--;
        if (go_check_in == 0) check_go();
      end
      // Frame start, snapshot of the expected status
      if (cs_d && !cs) begin
        first_word  = 1'b1;
        status_read = 1'b1;
        status_exp.write_count = count_m;
        status_exp.rsvd        = '0;
        status_exp.overrun     = overrun_m;
        status_exp.go          = go_m;
        check_go();
      end
      if (cs) begin
        bit_n = 0;
      end else if (sclk && !sclk_d) begin
        word_sr = {word_sr[`SPI_WORD_BITS-2:0], mosi};
        miso_sr = {miso_sr[`SPI_WORD_BITS-2:0], miso};
        bit_n++;
        if (bit_n == `SPI_WORD_BITS) begin
          bit_n    = 0;
          new_word = word_sr;
          apply_in = RX_DELAY;
          if (status_read && miso_sr !== status_exp) begin
            $display("FAILED %0t: status on miso %h, expected %h",
                     $time, miso_sr, status_exp);
            errors++;
          end
          status_read = 1'b0;
        end
      end
      cs_d   = cs;
      sclk_d = sclk;
    end
  end

  // Nothing may be left in flight at the end
  always @(posedge end_of_test) begin
    if (exp_addr_q.size() != 0) begin
      $display("%0d expected memory writes never arrived", exp_addr_q.size());
      errors++;
    end
    check_go();
  end

endmodule

`default_nettype wire

//--- design/spi_mem_loader.sv
/*
 * SPI loader top: receiver and transmitter sharing the SPI frame,
 * and the write sequencer driving the memory port and go
 */

`timescale 1ns/100ps
`default_nettype none

module spi_mem_loader
  import spi_loader_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // SPI pins, mode 0
  input  logic     cs,
  input  logic     sclk,
  input  logic     mosi,
  output logic     miso,

  // Memory write port
  output mem_req_t mem_req,
  output logic     mem_req_val,
  input  logic     mem_req_rdy,

  // Processor enable
  output logic     go
);

  spi_edges_t  edges;
  spi_word_u   rx_word;
  logic        rx_push;
  logic        tx_reload;
  spi_status_t status;

  // ----------------------------------------------------------
  // SPI side
  // ----------------------------------------------------------

  spi_word_rx u_rx (
    .clk     (clk),
    .rst     (rst),
    .cs      (cs),
    .sclk    (sclk),
    .mosi    (mosi),
    .edges   (edges),
    .rx_word (rx_word),
    .rx_push (rx_push)
  );

  // Same edges as the receiver, so both count the same bits
  spi_word_tx u_tx (
    .clk       (clk),
    .rst       (rst),
    .edges     (edges),
    .status    (status),
    .miso      (miso),
    .tx_reload (tx_reload)
  );

  // ----------------------------------------------------------
  // Memory side
  // ----------------------------------------------------------

  spi_write_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .rx_word     (rx_word),
    .rx_push     (rx_push),
    .tx_reload   (tx_reload),
    .mem_req     (mem_req),
    .mem_req_val (mem_req_val),
    .mem_req_rdy (mem_req_rdy),
    .go          (go),
    .status      (status)
  );

endmodule

`default_nettype wire

//--- design/spi_write_sequencer.sv
/*
 * Write sequencer: pairs received addresses with data, issues
 * valid/ready memory writes, drives go and keeps the status word
 */

`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_macros.svh"

module spi_write_sequencer
  import spi_loader_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  spi_word_u   rx_word,
  input  logic        rx_push,
  input  logic        tx_reload,

  output mem_req_t    mem_req,
  output logic        mem_req_val,
  input  logic        mem_req_rdy,

  output logic        go,
  output spi_status_t status
);

  typedef enum logic [1:0] {
    WAIT_ADDR,
    WAIT_DATA,
    WAIT_MEM,
    SET_GO
  } seq_state_t;

  seq_state_t state_q;
  seq_state_t state_d;

  logic [`SPI_WORD_BITS-1:0]     addr_q;
  spi_word_u                     data_q;
  logic [`STATUS_COUNT_BITS-1:0] write_count_q;
  logic                          overrun_q;
  logic                          push_q;
  logic                          drop_q;
  logic                          first_word_q;

  logic addr_take;
  logic data_take;
  logic drop;
  logic xfer;
  logic start_reload;
  logic word_reload;

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------

  // A word arriving in SET_GO is still an address
  assign addr_take = rx_push && (state_q == WAIT_ADDR || state_q == SET_GO);
  assign data_take = rx_push && (state_q == WAIT_DATA);
  // Stalled request, word lost
  assign drop      = rx_push && (state_q == WAIT_MEM);
  assign xfer      = mem_req_val && mem_req_rdy;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WAIT_ADDR: if (addr_take) state_d = WAIT_DATA;
      WAIT_DATA: begin
        if (data_take) begin
          if (addr_q == `LOADER_GO_ADDR) begin
            state_d = SET_GO;
          end else begin
            state_d = WAIT_MEM;
          end
        end
      end
      WAIT_MEM:  if (xfer) state_d = WAIT_ADDR;
      SET_GO:    state_d = addr_take ? WAIT_DATA : WAIT_ADDR;
      default:   state_d = WAIT_ADDR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= WAIT_ADDR;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // Address and data, held until the transfer
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (addr_take) begin
      addr_q <= rx_word.raw;
    end
    if (data_take) begin
      data_q <= rx_word;
    end
  end

  // Control register write, decoded one cycle after the data push
  always_ff @(posedge clk) begin
    if (rst) begin
      go <= 1'b1;
    end else if (state_q == SET_GO) begin
      go <= data_q.ctrl.go_en;
    end
  end

  assign mem_req_val  = (state_q == WAIT_MEM);
  assign mem_req.op   = `MEM_OP_WRITE;
  assign mem_req.addr = addr_q;
  assign mem_req.len  = '1;
  assign mem_req.data = data_q.raw;

  // ----------------------------------------------------------
  // Status counters
  // ----------------------------------------------------------

  // A reload right after a push is a word boundary, else a frame start
  assign start_reload = tx_reload && !push_q;
  assign word_reload  = tx_reload && push_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      write_count_q <= '0;
      overrun_q     <= 1'b0;
      push_q        <= 1'b0;
      drop_q        <= 1'b0;
      first_word_q  <= 1'b0;
    end else begin
      push_q <= rx_push;
      drop_q <= drop;
      if (xfer) begin
        write_count_q <= write_count_q + 1'b1;
      end
      if (start_reload) begin
        first_word_q <= 1'b1;
      end else if (word_reload) begin
        first_word_q <= 1'b0;
      end
      // Frame start snapshot has been shifted out by now
      // Keep only a drop of that first word itself
      if (drop) begin
        overrun_q <= 1'b1;
      end else if (word_reload && first_word_q) begin
        overrun_q <= drop_q;
      end
    end
  end

  assign status.write_count = write_count_q;
  assign status.rsvd        = '0;
  assign status.overrun     = overrun_q;
  assign status.go          = go;

endmodule

`default_nettype wire

//--- design/spi_word_tx.sv
/*
 * SPI transmitter: latches the status word at frame start and after
 * each word, then shifts it out MSB first on miso
 */

`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_macros.svh"

module spi_word_tx
  import spi_loader_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  spi_edges_t  edges,
  input  spi_status_t status,

  output logic        miso,
  output logic        tx_reload
);

  localparam int CNT_BITS = $clog2(`SPI_WORD_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`SPI_WORD_BITS - 1);

  logic [`SPI_WORD_BITS-1:0] shift_q;
  logic [CNT_BITS-1:0]       bit_cnt;
  logic                      word_done;

  // ----------------------------------------------------------
  // Bit counter on sclk rise, in step with the receiver
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt   <= '0;
      word_done <= 1'b0;
    end else begin
      word_done <= 1'b0;
      if (edges.frame_start) begin
        bit_cnt <= '0;
      end else if (edges.sclk_rise && edges.active) begin
        if (bit_cnt == LAST_BIT) begin
          bit_cnt   <= '0;
          word_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Status shift register
  // ----------------------------------------------------------

  // The falling edge right after a word boundary keeps the new MSB
  // on miso, so no shift while the count is back at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      shift_q   <= '0;
      tx_reload <= 1'b0;
    end else begin
      tx_reload <= 1'b0;
      if (edges.frame_start || word_done) begin
        shift_q   <= status;
        tx_reload <= 1'b1;
      end else if (edges.sclk_fall && edges.active && bit_cnt != '0) begin
        shift_q <= {shift_q[`SPI_WORD_BITS-2:0], 1'b0};
      end
    end
  end

  assign miso = shift_q[`SPI_WORD_BITS-1];

endmodule

`default_nettype wire

//--- design/spi_word_rx.sv
/*
 * SPI receiver: pin synchronizers, sclk and cs edge detection,
 * and word assembly with a one-cycle push per completed word
 */

`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_macros.svh"

module spi_word_rx
  import spi_loader_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       cs,
  input  logic       sclk,
  input  logic       mosi,

  output spi_edges_t edges,
  output spi_word_u  rx_word,
  output logic       rx_push
);

  localparam int SYNC_N   = `SPI_SYNC_STAGES;
  localparam int CNT_BITS = $clog2(`SPI_WORD_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`SPI_WORD_BITS - 1);

  logic [SYNC_N-1:0]   cs_sync;
  logic [SYNC_N-1:0]   sclk_sync;
  logic [SYNC_N-1:0]   mosi_sync;
  logic                cs_prev;
  logic                sclk_prev;
  logic                frame_end;
  logic [CNT_BITS-1:0] bit_cnt;

  // ----------------------------------------------------------
  // Synchronizers and edge register
  // ----------------------------------------------------------

  // cs idles high so no false frame start out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cs_sync   <= '1;
      sclk_sync <= '0;
      cs_prev   <= 1'b1;
      sclk_prev <= 1'b0;
    end else begin
      cs_sync   <= {cs_sync[SYNC_N-2:0], cs};
      sclk_sync <= {sclk_sync[SYNC_N-2:0], sclk};
      cs_prev   <= cs_sync[SYNC_N-1];
      sclk_prev <= sclk_sync[SYNC_N-1];
    end
  end

  // Data pin, same depth as sclk so sampling lines up
  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[SYNC_N-2:0], mosi};
  end

  assign edges.sclk_rise   = sclk_sync[SYNC_N-1] & ~sclk_prev;
  assign edges.sclk_fall   = ~sclk_sync[SYNC_N-1] & sclk_prev;
  assign edges.frame_start = ~cs_sync[SYNC_N-1] & cs_prev;
  assign edges.active      = ~cs_sync[SYNC_N-1];
  assign edges.mosi_bit    = mosi_sync[SYNC_N-1];

  // cs rising
  assign frame_end = cs_sync[SYNC_N-1] & ~cs_prev;

  // ----------------------------------------------------------
  // Word assembly
  // ----------------------------------------------------------

  // Partial word dropped on cs rise
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= '0;
      rx_push <= 1'b0;
    end else begin
      rx_push <= 1'b0;
      if (frame_end) begin
        bit_cnt <= '0;
      end else if (edges.sclk_rise && edges.active) begin
        if (bit_cnt == LAST_BIT) begin
          bit_cnt <= '0;
          rx_push <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // MSB first, word complete in the push cycle
  always_ff @(posedge clk) begin
    if (edges.sclk_rise && edges.active) begin
      rx_word.raw <= {rx_word.raw[`SPI_WORD_BITS-2:0], edges.mosi_bit};
    end
  end

endmodule

`default_nettype wire

//--- design/spi_loader_pkg.sv
/*
 * Types of the SPI memory loader: memory request, synchronized SPI
 * events, status word and the two views of a received word
 */

`default_nettype none

`include "spi_loader_macros.svh"

package spi_loader_pkg;

  // Memory request, 69 bits
  typedef struct packed {
    logic                         op;
    logic [`SPI_WORD_BITS-1:0]    addr;
    logic [`MEM_LEN_BITS-1:0]     len;
    logic [`SPI_WORD_BITS-1:0]    data;
  } mem_req_t;

  // SPI pin events in the clk domain
  typedef struct packed {
    logic sclk_rise;
    logic sclk_fall;
    logic frame_start;
    logic active;
    logic mosi_bit;
  } spi_edges_t;

  // Status word, go in the LSB
  typedef struct packed {
    logic [`STATUS_COUNT_BITS-1:0] write_count;
    logic [`STATUS_RSVD_BITS-1:0]  rsvd;
    logic                          overrun;
    logic                          go;
  } spi_status_t;

  // Control register view of a data word
  typedef struct packed {
    logic [`SPI_WORD_BITS-2:0] rsvd;
    logic                      go_en;
  } spi_ctrl_t;

  // Received word, plain memory value or control register write
  typedef union packed {
    logic [`SPI_WORD_BITS-1:0] raw;
    spi_ctrl_t                 ctrl;
  } spi_word_u;

endpackage

`default_nettype wire

//--- design/spi_loader_macros.svh
/*
 * Shared constants of the SPI memory loader: word width, go address,
 * pin synchronizer depth, memory request fields and status field widths
 */

`ifndef SPI_LOADER_MACROS_SVH
`define SPI_LOADER_MACROS_SVH

// SPI word, sent MSB first
`define SPI_WORD_BITS 32

// Address that selects the control register instead of memory
`define LOADER_GO_ADDR 32'h0000_0000

// Flops per SPI pin before edge detection
`define SPI_SYNC_STAGES 2

// Memory request encodings
`define MEM_LEN_BITS 4
`define MEM_OP_WRITE 1'b1

// Status word layout
`define STATUS_COUNT_BITS 16
`define STATUS_RSVD_BITS (`SPI_WORD_BITS - `STATUS_COUNT_BITS - 2)

`endif
